/* include/wr_guard_macros.svh */
// Sizing constants for the write guard, included by its packages and RTL
`ifndef WR_GUARD_MACROS_SVH
`define WR_GUARD_MACROS_SVH

// Linked-data entries, one per outstanding write
`define WR_GUARD_MAX_TXNS 4

// Head-tail entries, one per active ID
`define WR_GUARD_HT_CAP 4

// Bus field widths
`define WR_GUARD_ID_W 4
`define WR_GUARD_LEN_W 8

// Budget counter width
`define WR_GUARD_CNT_W 11

// Countdown prescaler, must be a power of two
`define WR_GUARD_PRESC_DIV 4

`endif

/* logic/wr_bus_pkg.sv */
// Field types of the monitored AW and B channels, shared by guard RTL and testbench
`include "wr_guard_macros.svh"

package wr_bus_pkg;

  // Transaction ID, same width on AW and B
  typedef logic [`WR_GUARD_ID_W-1:0] id_t;

  // AW burst length, beats minus one
  typedef logic [`WR_GUARD_LEN_W-1:0] len_t;

endpackage

/* logic/wr_track_pkg.sv */
// Tracker table, index, counter and interrupt types used across the write guard
`include "wr_guard_macros.svh"

package wr_track_pkg;

  // Table indices
  typedef logic [$clog2(`WR_GUARD_HT_CAP)-1:0] ht_idx_t;
  typedef logic [$clog2(`WR_GUARD_MAX_TXNS)-1:0] ld_idx_t;

  // Remaining budget of one write, in prescaled ticks
  typedef logic [`WR_GUARD_CNT_W-1:0] cnt_t;

  // Per-ID list descriptor
  typedef struct packed {
    wr_bus_pkg::id_t id;
    ld_idx_t         head;
    ld_idx_t         tail;
    logic            free;
  } head_tail_t;

  // One outstanding write, chained by next
  typedef struct packed {
    wr_bus_pkg::id_t  id;
    wr_bus_pkg::len_t len;
    cnt_t             counter;
    ld_idx_t          next;
    logic             free;
  } linked_data_t;

  // Reason latched with the interrupt
  typedef enum logic [1:0] {
    IRQ_NONE          = 2'd0,
    IRQ_WR_TIMEOUT    = 2'd1,
    IRQ_UNWANTED_RESP = 2'd2
  } irq_cause_e;

endpackage

/* logic/wr_txn_manager.sv */
// Next-state logic for the write tracker tables: enqueue, dequeue, timeout and error flush
`timescale 1ns/10ps
`include "wr_guard_macros.svh"

module wr_txn_manager (
  input  logic                                             wr_en_i,
  input  wr_bus_pkg::id_t                                  aw_id_i,
  input  wr_bus_pkg::len_t                                 aw_len_i,
  input  logic                                             b_valid_i,
  input  logic                                             b_ready_i,
  input  wr_bus_pkg::id_t                                  b_id_i,
  input  logic                                             id_exists_i,
  input  wr_track_pkg::ht_idx_t                            rsp_idx_i,
  input  logic                                             no_in_id_match_i,
  input  wr_track_pkg::ht_idx_t                            match_in_idx_i,
  input  wr_track_pkg::ht_idx_t                            head_tail_free_idx_i,
  input  wr_track_pkg::ld_idx_t                            linked_data_free_idx_i,
  input  wr_track_pkg::cnt_t                               accum_budget_i,
  input  wr_track_pkg::head_tail_t [`WR_GUARD_HT_CAP-1:0]    head_tail_q_i,
  input  wr_track_pkg::linked_data_t [`WR_GUARD_MAX_TXNS-1:0] linked_data_q_i,
  output wr_track_pkg::head_tail_t [`WR_GUARD_HT_CAP-1:0]    head_tail_d_o,
  output wr_track_pkg::linked_data_t [`WR_GUARD_MAX_TXNS-1:0] linked_data_d_o,
  output logic                                             timeout_o,
  output logic                                             unwanted_o,
  output wr_bus_pkg::id_t                                  offending_id_o,
  output logic                                             latency_valid_o,
  output wr_track_pkg::cnt_t                               latency_o
);

  localparam int unsigned LenShift = $clog2(`WR_GUARD_PRESC_DIV);

  logic                  b_taken;
  logic                  error;
  logic                  pop_last;
  logic                  reopen;
  wr_track_pkg::ld_idx_t head_idx;
  wr_track_pkg::ht_idx_t new_ht_idx;
  wr_track_pkg::cnt_t    txn_budget;

  assign b_taken  = b_valid_i && b_ready_i;
  assign head_idx = head_tail_q_i[rsp_idx_i].head;
  assign pop_last = head_idx == head_tail_q_i[rsp_idx_i].tail;

  // Budget covers everything queued ahead plus this burst
  assign txn_budget = accum_budget_i + wr_track_pkg::cnt_t'(aw_len_i >> LenShift) +
                      wr_track_pkg::cnt_t'(2);

  // Expiry scan, the highest expired index names the offender
  always_comb begin
    timeout_o      = 1'b0;
    offending_id_o = b_id_i;
    for (int i = 0; i < `WR_GUARD_MAX_TXNS; i++) begin
      if (!linked_data_q_i[i].free && linked_data_q_i[i].counter == '0) begin
        timeout_o      = 1'b1;
        offending_id_o = linked_data_q_i[i].id;
      end
    end
  end

  // A B during a timeout is dropped
  assign latency_valid_o = b_taken && !timeout_o && id_exists_i;
  assign unwanted_o      = b_taken && !timeout_o && !id_exists_i;
  assign latency_o       = linked_data_q_i[head_idx].counter;
  assign error           = timeout_o || unwanted_o;

  // Same ID popping its last entry while a new AW arrives for it
  assign reopen = latency_valid_o && pop_last && !no_in_id_match_i &&
                  (rsp_idx_i == match_in_idx_i);
  assign new_ht_idx = no_in_id_match_i ? head_tail_free_idx_i : match_in_idx_i;

  always_comb begin
    head_tail_d_o   = head_tail_q_i;
    linked_data_d_o = linked_data_q_i;

    // Pop the oldest write of the responding ID
    if (latency_valid_o) begin
      linked_data_d_o[head_idx]      = '0;
      linked_data_d_o[head_idx].free = 1'b1;
      if (pop_last) begin
        head_tail_d_o[rsp_idx_i]      = '0;
        head_tail_d_o[rsp_idx_i].free = 1'b1;
      end else begin
        head_tail_d_o[rsp_idx_i].head = linked_data_q_i[head_idx].next;
      end
    end

    // Append the accepted AW to its ID list
    if (wr_en_i) begin
      if (no_in_id_match_i || reopen) begin
        head_tail_d_o[new_ht_idx] = '{
          id:   aw_id_i,
          head: linked_data_free_idx_i,
          tail: linked_data_free_idx_i,
          free: 1'b0
        };
      end else begin
        linked_data_d_o[head_tail_q_i[match_in_idx_i].tail].next = linked_data_free_idx_i;
        head_tail_d_o[match_in_idx_i].tail = linked_data_free_idx_i;
      end
      linked_data_d_o[linked_data_free_idx_i] = '{
        id:      aw_id_i,
        len:     aw_len_i,
        counter: txn_budget,
        next:    '0,
        free:    1'b0
      };
    end

    // Any error empties both tables, enqueue included
    if (error) begin
      for (int i = 0; i < `WR_GUARD_MAX_TXNS; i++) begin
        linked_data_d_o[i]      = '0;
        linked_data_d_o[i].free = 1'b1;
      end
      for (int i = 0; i < `WR_GUARD_HT_CAP; i++) begin
        head_tail_d_o[i]      = '0;
        head_tail_d_o[i].free = 1'b1;
      end
    end
  end

endmodule

/* logic/wr_txn_tables.sv */
// Tracker table registers with searches, budget sum, prescaled countdown and AW gating
`timescale 1ns/10ps
`include "wr_guard_macros.svh"

module wr_txn_tables (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic                                              mst_aw_valid_i,
  input  logic                                              slv_aw_ready_i,
  input  wr_bus_pkg::id_t                                   aw_id_i,
  input  wr_bus_pkg::len_t                                  aw_len_i,
  input  wr_bus_pkg::id_t                                   b_id_i,
  input  wr_track_pkg::head_tail_t [`WR_GUARD_HT_CAP-1:0]     head_tail_d_i,
  input  wr_track_pkg::linked_data_t [`WR_GUARD_MAX_TXNS-1:0] linked_data_d_i,
  output logic                                              mst_aw_ready_o,
  output logic                                              slv_aw_valid_o,
  output logic                                              wr_en_o,
  output logic                                              id_exists_o,
  output wr_track_pkg::ht_idx_t                             rsp_idx_o,
  output logic                                              no_in_id_match_o,
  output wr_track_pkg::ht_idx_t                             match_in_idx_o,
  output wr_track_pkg::ht_idx_t                             head_tail_free_idx_o,
  output wr_track_pkg::ld_idx_t                             linked_data_free_idx_o,
  output wr_track_pkg::cnt_t                                accum_budget_o,
  output wr_track_pkg::head_tail_t [`WR_GUARD_HT_CAP-1:0]     head_tail_q_o,
  output wr_track_pkg::linked_data_t [`WR_GUARD_MAX_TXNS-1:0] linked_data_q_o
);

  localparam int unsigned PrescW   = $clog2(`WR_GUARD_PRESC_DIV);
  localparam int unsigned LenShift = $clog2(`WR_GUARD_PRESC_DIV);

  logic [PrescW-1:0] presc_q;
  logic              presc_tick;
  logic              ht_full;
  logic              ld_full;
  logic              full;

  assign presc_tick = presc_q == PrescW'(`WR_GUARD_PRESC_DIV - 1);

  // Lowest-index free slots, scanned downwards so the lowest wins
  always_comb begin
    ht_full              = 1'b1;
    ld_full              = 1'b1;
    head_tail_free_idx_o = '0;
    linked_data_free_idx_o = '0;
    for (int i = `WR_GUARD_HT_CAP - 1; i >= 0; i--) begin
      if (head_tail_q_o[i].free) begin
        ht_full              = 1'b0;
        head_tail_free_idx_o = wr_track_pkg::ht_idx_t'(i);
      end
    end
    for (int i = `WR_GUARD_MAX_TXNS - 1; i >= 0; i--) begin
      if (linked_data_q_o[i].free) begin
        ld_full                = 1'b0;
        linked_data_free_idx_o = wr_track_pkg::ld_idx_t'(i);
      end
    end
  end

  // ID lookups for AW and B, plus the outstanding budget
  always_comb begin
    no_in_id_match_o = 1'b1;
    match_in_idx_o   = '0;
    id_exists_o      = 1'b0;
    rsp_idx_o        = '0;
    accum_budget_o   = '0;
    for (int i = 0; i < `WR_GUARD_HT_CAP; i++) begin
      if (!head_tail_q_o[i].free && head_tail_q_o[i].id == aw_id_i) begin
        no_in_id_match_o = 1'b0;
        match_in_idx_o   = wr_track_pkg::ht_idx_t'(i);
      end
      if (!head_tail_q_o[i].free && head_tail_q_o[i].id == b_id_i) begin
        id_exists_o = 1'b1;
        rsp_idx_o   = wr_track_pkg::ht_idx_t'(i);
      end
    end
    for (int i = 0; i < `WR_GUARD_MAX_TXNS; i++) begin
      if (!linked_data_q_o[i].free) begin
        accum_budget_o = accum_budget_o +
                         wr_track_pkg::cnt_t'(linked_data_q_o[i].len >> LenShift);
      end
    end
  end

  assign full           = ht_full || ld_full;
  assign mst_aw_ready_o = slv_aw_ready_i && !full;
  assign slv_aw_valid_o = mst_aw_valid_i && !full;
  assign wr_en_o        = mst_aw_valid_i && mst_aw_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      presc_q <= '0;
      for (int i = 0; i < `WR_GUARD_HT_CAP; i++) begin
        head_tail_q_o[i]      <= '0;
        head_tail_q_o[i].free <= 1'b1;
      end
      for (int i = 0; i < `WR_GUARD_MAX_TXNS; i++) begin
        linked_data_q_o[i]      <= '0;
        linked_data_q_o[i].free <= 1'b1;
      end
    end else begin
      // Wraps at the division since it is a power of two
      presc_q       <= presc_q + 1'b1;
      head_tail_q_o <= head_tail_d_i;
      for (int i = 0; i < `WR_GUARD_MAX_TXNS; i++) begin
        linked_data_q_o[i] <= linked_data_d_i[i];
        if (presc_tick && !linked_data_d_i[i].free && linked_data_d_i[i].counter != '0) begin
          linked_data_q_o[i].counter <= linked_data_d_i[i].counter - 1'b1;
        end
      end
    end
  end

endmodule

/* logic/wr_guard_regs.sv */
// Sticky interrupt status and last write latency, cleared by a software pulse
`timescale 1ns/10ps

module wr_guard_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     timeout_i,
  input  logic                     unwanted_i,
  input  wr_bus_pkg::id_t          offending_id_i,
  input  logic                     latency_valid_i,
  input  wr_track_pkg::cnt_t       latency_i,
  input  logic                     irq_clr_i,
  output logic                     irq_o,
  output wr_track_pkg::irq_cause_e irq_cause_o,
  output wr_bus_pkg::id_t          irq_txn_id_o,
  output wr_track_pkg::cnt_t       latency_o
);

  logic                     irq_q;
  wr_track_pkg::irq_cause_e cause_q;
  wr_bus_pkg::id_t          txn_id_q;
  wr_track_pkg::cnt_t       latency_q;
  logic                     event_hit;

  assign event_hit = timeout_i || unwanted_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q    <= 1'b0;
      cause_q  <= wr_track_pkg::IRQ_NONE;
      txn_id_q <= '0;
    end else if (irq_clr_i) begin
      // Clear beats an event in the same cycle
      irq_q    <= 1'b0;
      cause_q  <= wr_track_pkg::IRQ_NONE;
      txn_id_q <= '0;
    end else if (event_hit && !irq_q) begin
      // Only the first cause is kept until cleared
      irq_q    <= 1'b1;
      cause_q  <= timeout_i ? wr_track_pkg::IRQ_WR_TIMEOUT : wr_track_pkg::IRQ_UNWANTED_RESP;
      txn_id_q <= offending_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      latency_q <= '0;
    end else if (latency_valid_i) begin
      latency_q <= latency_i;
    end
  end

  assign irq_o        = irq_q;
  assign irq_cause_o  = cause_q;
  assign irq_txn_id_o = txn_id_q;
  assign latency_o    = latency_q;

endmodule

/* logic/wr_guard_top.sv */
// Write guard top level between manager and subordinate, the DUT of the testbench
`timescale 1ns/10ps
`include "wr_guard_macros.svh"

module wr_guard_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     mst_aw_valid_i,
  input  wr_bus_pkg::id_t          mst_aw_id_i,
  input  wr_bus_pkg::len_t         mst_aw_len_i,
  input  logic                     slv_aw_ready_i,
  input  logic                     slv_b_valid_i,
  input  wr_bus_pkg::id_t          slv_b_id_i,
  input  logic                     mst_b_ready_i,
  input  logic                     irq_clr_i,
  output logic                     mst_aw_ready_o,
  output logic                     slv_aw_valid_o,
  output wr_bus_pkg::id_t          slv_aw_id_o,
  output wr_bus_pkg::len_t         slv_aw_len_o,
  output logic                     mst_b_valid_o,
  output wr_bus_pkg::id_t          mst_b_id_o,
  output logic                     slv_b_ready_o,
  output logic                     irq_o,
  output wr_track_pkg::irq_cause_e irq_cause_o,
  output wr_bus_pkg::id_t          irq_txn_id_o,
  output wr_track_pkg::cnt_t       latency_o
);

  wr_track_pkg::head_tail_t [`WR_GUARD_HT_CAP-1:0]     head_tail_q;
  wr_track_pkg::head_tail_t [`WR_GUARD_HT_CAP-1:0]     head_tail_d;
  wr_track_pkg::linked_data_t [`WR_GUARD_MAX_TXNS-1:0] linked_data_q;
  wr_track_pkg::linked_data_t [`WR_GUARD_MAX_TXNS-1:0] linked_data_d;

  logic                  wr_en;
  logic                  id_exists;
  logic                  no_in_id_match;
  logic                  timeout;
  logic                  unwanted;
  logic                  latency_valid;
  wr_track_pkg::ht_idx_t rsp_idx;
  wr_track_pkg::ht_idx_t match_in_idx;
  wr_track_pkg::ht_idx_t ht_free_idx;
  wr_track_pkg::ld_idx_t ld_free_idx;
  wr_track_pkg::cnt_t    accum_budget;
  wr_track_pkg::cnt_t    latency;
  wr_bus_pkg::id_t       offending_id;

  // Payload and B channel go straight through
  assign slv_aw_id_o   = mst_aw_id_i;
  assign slv_aw_len_o  = mst_aw_len_i;
  assign mst_b_valid_o = slv_b_valid_i;
  assign mst_b_id_o    = slv_b_id_i;
  assign slv_b_ready_o = mst_b_ready_i;

  wr_txn_tables u_tables (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .mst_aw_valid_i         (mst_aw_valid_i),
    .slv_aw_ready_i         (slv_aw_ready_i),
    .aw_id_i                (mst_aw_id_i),
    .aw_len_i               (mst_aw_len_i),
    .b_id_i                 (slv_b_id_i),
    .head_tail_d_i          (head_tail_d),
    .linked_data_d_i        (linked_data_d),
    .mst_aw_ready_o         (mst_aw_ready_o),
    .slv_aw_valid_o         (slv_aw_valid_o),
    .wr_en_o                (wr_en),
    .id_exists_o            (id_exists),
    .rsp_idx_o              (rsp_idx),
    .no_in_id_match_o       (no_in_id_match),
    .match_in_idx_o         (match_in_idx),
    .head_tail_free_idx_o   (ht_free_idx),
    .linked_data_free_idx_o (ld_free_idx),
    .accum_budget_o         (accum_budget),
    .head_tail_q_o          (head_tail_q),
    .linked_data_q_o        (linked_data_q)
  );

  wr_txn_manager u_manager (
    .wr_en_i                (wr_en),
    .aw_id_i                (mst_aw_id_i),
    .aw_len_i               (mst_aw_len_i),
    .b_valid_i              (slv_b_valid_i),
    .b_ready_i              (mst_b_ready_i),
    .b_id_i                 (slv_b_id_i),
    .id_exists_i            (id_exists),
    .rsp_idx_i              (rsp_idx),
    .no_in_id_match_i       (no_in_id_match),
    .match_in_idx_i         (match_in_idx),
    .head_tail_free_idx_i   (ht_free_idx),
    .linked_data_free_idx_i (ld_free_idx),
    .accum_budget_i         (accum_budget),
    .head_tail_q_i          (head_tail_q),
    .linked_data_q_i        (linked_data_q),
    .head_tail_d_o          (head_tail_d),
    .linked_data_d_o        (linked_data_d),
    .timeout_o              (timeout),
    .unwanted_o             (unwanted),
    .offending_id_o         (offending_id),
    .latency_valid_o        (latency_valid),
    .latency_o              (latency)
  );

  wr_guard_regs u_regs (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .timeout_i       (timeout),
    .unwanted_i      (unwanted),
    .offending_id_i  (offending_id),
    .latency_valid_i (latency_valid),
    .latency_i       (latency),
    .irq_clr_i       (irq_clr_i),
    .irq_o           (irq_o),
    .irq_cause_o     (irq_cause_o),
    .irq_txn_id_o    (irq_txn_id_o),
    .latency_o       (latency_o)
  );

endmodule

/* verification/wr_guard_tb.sv */
// Self-checking testbench for wr_guard_top with LFSR stimulus and a cycle-level model
`timescale 1ns/10ps
`include "wr_guard_macros.svh"

module wr_guard_tb;

  localparam int MaxTxns = `WR_GUARD_MAX_TXNS;
  localparam int Div = `WR_GUARD_PRESC_DIV;
  localparam int LenShift = $clog2(`WR_GUARD_PRESC_DIV);
  localparam int ResetCycles = 16;
  localparam int RandCycles = 300;
  localparam int TailCycles = 100;
  localparam int TxnEstimate = RandCycles + TailCycles + 16;
  localparam int ModeIdle = 0, ModeRandom = 1, ModeFill = 2, ModePop = 3;
  localparam int ModeDrain = 4, ModeSingle = 5, ModeStray = 6, ModeClear = 7;

  logic clk, rst_n, aw_valid, slv_aw_ready, b_valid, b_ready, irq_clr;
  wr_bus_pkg::id_t aw_id, b_id, stray_id;
  wr_bus_pkg::len_t aw_len;
  logic mst_aw_ready, slv_aw_valid, mst_b_valid, slv_b_ready, irq;
  wr_bus_pkg::id_t slv_aw_id, mst_b_id, irq_txn_id;
  wr_bus_pkg::len_t slv_aw_len;
  wr_track_pkg::irq_cause_e irq_cause;
  wr_track_pkg::cnt_t latency;

  // Model state with one slot per linked-data entry
  logic [MaxTxns-1:0] m_used;
  wr_bus_pkg::id_t m_id [MaxTxns];
  wr_bus_pkg::len_t m_len [MaxTxns];
  wr_track_pkg::cnt_t m_cnt [MaxTxns];
  int m_seq [MaxTxns];
  int seq_ctr, m_phase, mode;
  logic m_irq;
  wr_track_pkg::irq_cause_e m_cause;
  wr_bus_pkg::id_t m_txn_id;
  wr_track_pkg::cnt_t m_lat;
  logic [31:0] lfsr_q;
  string test_name;

  wr_guard_top dut (
    .clk_i(clk), .rst_n_i(rst_n), .mst_aw_valid_i(aw_valid), .mst_aw_id_i(aw_id),
    .mst_aw_len_i(aw_len), .slv_aw_ready_i(slv_aw_ready), .slv_b_valid_i(b_valid),
    .slv_b_id_i(b_id), .mst_b_ready_i(b_ready), .irq_clr_i(irq_clr),
    .mst_aw_ready_o(mst_aw_ready), .slv_aw_valid_o(slv_aw_valid), .slv_aw_id_o(slv_aw_id),
    .slv_aw_len_o(slv_aw_len), .mst_b_valid_o(mst_b_valid), .mst_b_id_o(mst_b_id),
    .slv_b_ready_o(slv_b_ready), .irq_o(irq), .irq_cause_o(irq_cause),
    .irq_txn_id_o(irq_txn_id), .latency_o(latency)
  );

  always #50 clk = ~clk;

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic lsb;
    lsb = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic int occupied();
    int n;
    n = 0;
    for (int i = 0; i < MaxTxns; i++) n += int'(m_used[i]);
    return n;
  endfunction

  // ID of the first occupied slot at or after sel
  function automatic wr_bus_pkg::id_t pick_id(logic [1:0] sel);
    wr_bus_pkg::id_t id;
    int idx;
    id = '0;
    for (int k = MaxTxns - 1; k >= 0; k--) begin
      idx = (int'(sel) + k) % MaxTxns;
      if (m_used[idx]) id = m_id[idx];
    end
    return id;
  endfunction

  task automatic fail_now(string field, string exp_s, string act_s);
    $display("Fail %s %s: expected %s, actual %s", test_name, field, exp_s, act_s);
    $display("TESTBENCH FAILED");
    $fatal(1, "Mismatch on %s", field);
  endtask

  task automatic check_bit(string field, logic exp, logic act);
    if (exp !== act) fail_now(field, $sformatf("%0b", exp), $sformatf("%0b", act));
  endtask

  task automatic check_cause(string field, wr_track_pkg::irq_cause_e exp,
                             wr_track_pkg::irq_cause_e act);
    if (exp !== act) fail_now(field, exp.name(), act.name());
  endtask

  task automatic check_id(string field, wr_bus_pkg::id_t exp, wr_bus_pkg::id_t act);
    if (exp !== act) fail_now(field, $sformatf("%0h", exp), $sformatf("%0h", act));
  endtask

  task automatic check_len(string field, wr_bus_pkg::len_t exp, wr_bus_pkg::len_t act);
    if (exp !== act) fail_now(field, $sformatf("%0h", exp), $sformatf("%0h", act));
  endtask

  task automatic check_cnt(string field, wr_track_pkg::cnt_t exp, wr_track_pkg::cnt_t act);
    if (exp !== act) fail_now(field, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  // One clock of the guard from the inputs of the cycle that just ended
  task automatic model_step();
    logic tmo, bad_b;
    wr_bus_pkg::id_t off_id;
    wr_track_pkg::cnt_t budget;
    int pop_slot, free_slot;
    tmo = 1'b0;
    off_id = b_id;
    pop_slot = -1;
    free_slot = -1;
    budget = wr_track_pkg::cnt_t'(aw_len >> LenShift) + wr_track_pkg::cnt_t'(2);
    for (int i = 0; i < MaxTxns; i++) begin
      if (m_used[i]) begin
        budget += wr_track_pkg::cnt_t'(m_len[i] >> LenShift);
        if (m_cnt[i] == '0) begin
          tmo = 1'b1;
          off_id = m_id[i];
        end
        if (m_id[i] == b_id && (pop_slot < 0 || m_seq[i] < m_seq[pop_slot])) pop_slot = i;
      end else if (free_slot < 0) begin
        free_slot = i;
      end
    end
    bad_b = b_valid && b_ready && !tmo && pop_slot < 0;
    if (irq_clr) begin
      m_irq = 1'b0;
      m_cause = wr_track_pkg::IRQ_NONE;
      m_txn_id = '0;
    end else if ((tmo || bad_b) && !m_irq) begin
      m_irq = 1'b1;
      m_cause = tmo ? wr_track_pkg::IRQ_WR_TIMEOUT : wr_track_pkg::IRQ_UNWANTED_RESP;
      m_txn_id = off_id;
    end
    if (tmo || bad_b) begin
      m_used = '0;
    end else begin
      if (b_valid && b_ready) begin
        m_lat = m_cnt[pop_slot];
        m_used[pop_slot] = 1'b0;
      end
      if (aw_valid && slv_aw_ready && free_slot >= 0) begin
        m_used[free_slot] = 1'b1;
        m_id[free_slot] = aw_id;
        m_len[free_slot] = aw_len;
        m_cnt[free_slot] = budget;
        m_seq[free_slot] = seq_ctr;
        seq_ctr++;
      end
    end
    // Prescaled countdown
    if (m_phase == Div - 1) begin
      for (int i = 0; i < MaxTxns; i++) begin
        if (m_used[i] && m_cnt[i] != '0) m_cnt[i] = m_cnt[i] - 1'b1;
      end
    end
    m_phase = (m_phase + 1) % Div;
  endtask

  task automatic drive_inputs();
    aw_valid <= 1'b0;
    b_valid <= 1'b0;
    b_ready <= 1'b1;
    irq_clr <= 1'b0;
    slv_aw_ready <= 1'b1;
    case (mode)
      ModeRandom: begin
        aw_valid <= next_bit();
        slv_aw_ready <= rand_bits(2) != '0;
        aw_id <= wr_bus_pkg::id_t'(rand_bits(2));
        aw_len <= wr_bus_pkg::len_t'(rand_bits(8));
        b_valid <= occupied() != 0 && rand_bits(2) != '0;
        b_id <= pick_id(2'(rand_bits(2)));
        b_ready <= rand_bits(2) != '0;
        irq_clr <= m_irq;
      end
      ModeFill: begin
        aw_valid <= 1'b1;
        aw_id <= wr_bus_pkg::id_t'(rand_bits(2));
        aw_len <= 8'hff;
      end
      ModePop: begin
        b_valid <= 1'b1;
        b_id <= pick_id(2'(rand_bits(2)));
      end
      ModeDrain: begin
        b_valid <= occupied() != 0;
        b_id <= pick_id(2'd0);
        irq_clr <= m_irq;
      end
      ModeSingle: begin
        aw_valid <= occupied() == 0 && !m_irq;
        aw_id <= stray_id;
        aw_len <= '0;
      end
      ModeStray: begin
        b_valid <= 1'b1;
        b_id <= stray_id;
      end
      ModeClear: irq_clr <= 1'b1;
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    if (rst_n) model_step();
    drive_inputs();
  end

  always @(negedge clk) begin
    if (rst_n) begin
      check_bit("irq", m_irq, irq);
      check_cause("cause", m_cause, irq_cause);
      check_id("irq id", m_txn_id, irq_txn_id);
      check_cnt("latency", m_lat, latency);
      check_bit("aw ready", slv_aw_ready && occupied() < MaxTxns, mst_aw_ready);
      check_bit("aw valid", aw_valid && occupied() < MaxTxns, slv_aw_valid);
      check_id("aw id", aw_id, slv_aw_id);
      check_len("aw len", aw_len, slv_aw_len);
      check_id("b id", b_id, mst_b_id);
      check_bit("b valid", b_valid, mst_b_valid);
      check_bit("b ready", b_ready, slv_b_ready);
    end
  end

  task automatic pulse_mode(int m);
    mode = m;
    @(negedge clk);
    mode = ModeIdle;
  endtask

  task automatic drain();
    test_name = "drain";
    mode = ModeDrain;
    while (occupied() != 0 || m_irq) @(negedge clk);
    mode = ModeIdle;
  endtask

  // Watchdog
  initial begin
    repeat (ResetCycles + 40 * TxnEstimate) @(posedge clk);
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired before the tests finished");
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    aw_valid = 1'b0;
    aw_id = '0;
    aw_len = '0;
    slv_aw_ready = 1'b0;
    b_valid = 1'b0;
    b_id = '0;
    b_ready = 1'b1;
    irq_clr = 1'b0;
    lfsr_q = 32'hab18_90e9;
    m_used = '0;
    seq_ctr = 0;
    m_phase = 0;
    m_irq = 1'b0;
    m_cause = wr_track_pkg::IRQ_NONE;
    m_txn_id = '0;
    m_lat = '0;
    mode = ModeIdle;
    stray_id = 4'h5;
    test_name = "reset";
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    test_name = "random";
    mode = ModeRandom;
    repeat (RandCycles) @(negedge clk);
    drain();
    test_name = "full";
    mode = ModeFill;
    while (occupied() < MaxTxns) @(negedge clk);
    repeat (4) @(negedge clk);
    mode = ModePop;
    @(negedge clk);
    mode = ModeFill;
    while (occupied() < MaxTxns) @(negedge clk);
    drain();
    test_name = "timeout";
    mode = ModeSingle;
    while (!m_irq) @(negedge clk);
    mode = ModeIdle;
    check_cause("cause", wr_track_pkg::IRQ_WR_TIMEOUT, irq_cause);
    check_id("irq id", stray_id, irq_txn_id);
    pulse_mode(ModeClear);
    test_name = "late b";
    pulse_mode(ModeStray);
    @(negedge clk);
    check_cause("cause", wr_track_pkg::IRQ_UNWANTED_RESP, irq_cause);
    pulse_mode(ModeClear);
    test_name = "unknown id";
    stray_id = 4'hc;
    pulse_mode(ModeStray);
    @(negedge clk);
    check_cause("cause", wr_track_pkg::IRQ_UNWANTED_RESP, irq_cause);
    check_id("irq id", 4'hc, irq_txn_id);
    pulse_mode(ModeClear);
    @(negedge clk);
    check_cause("cause", wr_track_pkg::IRQ_NONE, irq_cause);
    test_name = "after clear";
    mode = ModeRandom;
    repeat (TailCycles) @(negedge clk);
    drain();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
logic/wr_bus_pkg.sv
logic/wr_track_pkg.sv
logic/wr_txn_manager.sv
logic/wr_txn_tables.sv
logic/wr_guard_regs.sv
logic/wr_guard_top.sv
verification/wr_guard_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wr_guard_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
